//--- coreFourThread.f
src/corePkg.sv
src/threadScheduler.sv
src/decodeStage.sv
src/registerFile.sv
src/executeStage.sv
src/memWriteback.sv
src/coreFourThread.sv
verif/coreFourThreadTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the four-thread core testbench with Verilator.
# The verdict comes from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
        -f coreFourThread.f --top-module coreFourThreadTb \
        --Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VcoreFourThreadTb > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
if [ "$runStatus" -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0

//--- verif/coreVectors.txt
// Word image: @000 script count, store count; @010 boot pc per thread
// @020 script: cycle, mask (bits 3:0 enable, 7:4 restart); @040 stores: thread adrs data byteEn
@000
00000005 0000000D
@010
00000000 00000400 00000800 00000C00
@020
0000000A 0000000D 00000028 0000000F 0000003C 00000007
00000046 00000087 00000048 0000000F
@040
00000000 00000100 00000008 0000000F
00000000 00000104 FFFFFFFC 0000000F
00000000 00000108 12345000 0000000F
00000001 00000200 00000007 0000000F
00000001 00000204 00000418 0000000F
00000001 00000208 00000428 0000000F
00000002 00000300 FFFFFFFE 00000001
00000002 00000304 FFFFFFFE 00000003
00000002 00000308 0000FFFC 0000000F
00000003 00000400 00000000 0000000F
00000003 00000404 00000055 0000000F
00000003 00000400 00000000 0000000F
00000003 00000404 00000055 0000000F
// Thread 0 ALU program
@400
00500093 FFD00113 402081B3 10302023 0020C233
40125293 10502223 12345337 10602423 0000006F
// Thread 1 branches and jumps
@500
00700093 00008463 20102023 00009463 20002223 0080016F 20002223
20202223 42C00193 00018267 20002423 20402423 0000006F
// Thread 2 byte and half-word loads and stores
@600
FFE00093 30100023 30101223 30000103 30405183 00310233 30402423 0000006F
// Thread 3 x0 writes, restarted by the script
@700
00900013 05500093 40002023 40102223 0000006F

//--- verif/coreFourThreadTb.sv
// Testbench for the four-thread barrel core
// Clock and reset, instruction and data memory models,
// vector loading, enable and restart script, store checks, timeout
`timescale 1ns/1ps
`default_nettype none

module coreFourThreadTb import corePkg::*; ();

    localparam int SCRIPT_BASE = 'h20;   // Cycle and mask pairs
    localparam int STORE_BASE  = 'h40;   // Thread, adrs, data, byte enable
    localparam int BOOT_BASE   = 'h10;
    localparam int IMEM_BASE   = 'h400;  // Program image

    logic   QClk = 1'b0;
    logic   reset = 1'b1;
    xlenT   instFetchQ101H = NOP;
    xlenT   memRdDataQ104H = '0;
    threadT threadEnable = '1;
    threadT threadRestart = '0;
    xlenT   pcQ100H, memAdrsQ103H, memWrDataQ103H;
    logic   memRdQ103H, memWrQ103H;
    byteEnT memByteEnQ103H;
    threadT threadQ103H;

    xlenT vecMem [0:2047];
    xlenT imem [0:1023];
    xlenT dmem [0:1023];
    int   scriptAt [0:15];
    int   nextRec [NUM_THREADS];
    int   offCycles [NUM_THREADS];
    int   numScript, numStores, storesLeft, timeoutLimit;
    int   cycle = 0;
    int   scriptIdx = 0;

    coreFourThread coreFourThread_i (
        .QClk, .reset, .pcQ100H, .instFetchQ101H, .memAdrsQ103H, .memWrDataQ103H,
        .memRdQ103H, .memWrQ103H, .memByteEnQ103H, .threadQ103H, .memRdDataQ104H,
        .threadEnable, .threadRestart
    );

    always #20 QClk = ~QClk;  // 40 ns period

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic int threadIndex(input threadT oneHot);
        int idx;
        idx = 0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (oneHot[t]) idx = t;
        end
        return idx;
    endfunction

    // Next expected record of a thread, numStores when none is left
    function automatic int findRecord(input int t, input int start);
        for (int r = start; r < numStores; r++) begin
            if (vecMem[STORE_BASE + 4*r] == t) return r;
        end
        return numStores;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////
    always @(posedge QClk) begin
        instFetchQ101H <= imem[pcQ100H[11:2]];       // Registered fetch
        if (memRdQ103H === 1'b1) begin
            memRdDataQ104H <= dmem[memAdrsQ103H[11:2]];  // Data next cycle
        end
        if (memWrQ103H === 1'b1) begin
            for (int b = 0; b < 4; b++) begin
                if (memByteEnQ103H[b]) begin
                    dmem[memAdrsQ103H[11:2]][8*b +: 8] <= memWrDataQ103H[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Enable script, restart pulses and timeout
    //////////////////////////////////////////////////////////////////////
    always @(posedge QClk) begin
        if (!reset) begin
            assert (cycle < timeoutLimit)
                else stopOnError($sformatf("Timeout after %0d cycles with %0d stores missing",
                                           cycle, storesLeft));
            cycle <= cycle + 1;
            threadRestart <= '0;  // One-cycle pulse
            if (scriptIdx < numScript && cycle == scriptAt[scriptIdx]) begin
                threadEnable  <= vecMem[SCRIPT_BASE + 2*scriptIdx + 1][3:0];
                threadRestart <= vecMem[SCRIPT_BASE + 2*scriptIdx + 1][7:4];
                scriptIdx     <= scriptIdx + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Store checks, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge QClk) begin
        int t;
        int r;
        if (reset) begin
            assert (memRdQ103H === 1'b0 && memWrQ103H === 1'b0)
                else stopOnError("Memory access seen during reset");
        end else if (memWrQ103H === 1'b1) begin
            assert ($onehot(threadQ103H))
                else stopOnError("Store carries a thread pointer that is not one-hot");
            t = threadIndex(threadQ103H);
            assert (offCycles[t] < 3)  // Only an in-flight store may finish
                else stopOnError($sformatf("Thread %0d stored while disabled", t));
            r = findRecord(t, nextRec[t]);
            assert (r < numStores)
                else stopOnError($sformatf("Unexpected extra store from thread %0d", t));
            assert (memAdrsQ103H == vecMem[STORE_BASE + 4*r + 1] &&
                    memWrDataQ103H == vecMem[STORE_BASE + 4*r + 2] &&
                    memByteEnQ103H == vecMem[STORE_BASE + 4*r + 3][3:0])
                else stopOnError($sformatf(
                    "MISMATCH at %0t: thread %0d stored %h/%h/%b, expected %h/%h/%b",
                    $time, t, memAdrsQ103H, memWrDataQ103H, memByteEnQ103H,
                    vecMem[STORE_BASE + 4*r + 1], vecMem[STORE_BASE + 4*r + 2],
                    vecMem[STORE_BASE + 4*r + 3][3:0]));
            nextRec[t] = r + 1;
            storesLeft = storesLeft - 1;
        end
        for (int k = 0; k < NUM_THREADS; k++) begin
            offCycles[k] = threadEnable[k] ? 0 : offCycles[k] + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int gapTotal;
        void'($urandom(32'hb14d));
        $readmemh("verif/coreVectors.txt", vecMem);
        numScript  = vecMem[0];
        numStores  = vecMem[1];
        storesLeft = numStores;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = vecMem[IMEM_BASE + i];
            dmem[i] <= {i[15:0], ~i[15:0]};  // Address-unique fill
        end
        for (int t = 0; t < NUM_THREADS; t++) begin
            nextRec[t]   = 0;
            offCycles[t] = 0;
        end
        gapTotal = 0;
        for (int i = 0; i < numScript; i++) begin
            gapTotal    = gapTotal + int'($urandom % 4);  // Random idle gap
            scriptAt[i] = int'(vecMem[SCRIPT_BASE + 2*i]) + gapTotal;
        end
        timeoutLimit = scriptAt[numScript-1] + 64 * numStores;

        repeat (8) @(posedge QClk);
        reset <= 1'b0;

        // Boot addresses appear in rotation order
        for (int k = 0; k < NUM_THREADS; k++) begin
            @(negedge QClk);
            assert (pcQ100H == vecMem[BOOT_BASE + k])
                else stopOnError($sformatf("MISMATCH at %0t: boot pc %h, expected %h",
                                           $time, pcQ100H, vecMem[BOOT_BASE + k]));
        end

        wait (storesLeft == 0 && scriptIdx == numScript);
        repeat (16) @(posedge QClk);  // Catch late extra stores
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/coreFourThread.sv
// Four-thread barrel RV32I core, top level
// Five-stage pipe Q100H fetch through Q104H write-back
// Thread pointer shifts, Q100H/Q101H PC flop, register read flops
`timescale 1ns/1ps
`default_nettype none

module coreFourThread import corePkg::*; #(
    parameter xlenT bootStride = 32'h400
) (
    input  logic   QClk,
    input  logic   reset,
    output xlenT   pcQ100H,          // To instruction memory
    input  xlenT   instFetchQ101H,   // Registered by the memory
    output xlenT   memAdrsQ103H,
    output xlenT   memWrDataQ103H,
    output logic   memRdQ103H,
    output logic   memWrQ103H,
    output byteEnT memByteEnQ103H,
    output threadT threadQ103H,
    input  xlenT   memRdDataQ104H,   // One cycle after a read
    input  threadT threadEnable,
    input  threadT threadRestart
);

    threadT     threadQ100H, threadQ101H, threadQ104H;
    xlenT       pcQ101H, pcQ102H, instructionQ102H, nextPcQ102H;
    xlenT       rs1DataQ101H, rs2DataQ101H, rs1DataQ102H, rs2DataQ102H;
    regPtrT     rs1PtrQ101H, rs2PtrQ101H, rdPtrQ103H, rdPtrQ104H;
    logic       insertNopQ101H, insertNopQ102H;
    logic       jalQ102H, jalrQ102H, branchQ102H, iTypeImmQ102H, luiQ102H, auiPcQ102H;
    logic       memRdQ102H, memWrQ102H, storeQ102H, regWrQ102H, memToRegQ102H, pcToRegQ102H;
    xlenT       aluOutQ103H, storeDataQ103H, pcPlus4Q103H, rdDataQ104H;
    logic [2:0] funct3Q103H;
    logic       regWrQ103H, memToRegQ103H, pcToRegQ103H, regWrQ104H;

    ///////////////////////////////////////////////////////////////////
    // Thread pointer per stage, each one slot behind the last
    ///////////////////////////////////////////////////////////////////
    assign threadQ101H = {threadQ100H[0], threadQ100H[NUM_THREADS-1:1]};
    assign threadQ103H = {threadQ100H[NUM_THREADS-2:0], threadQ100H[NUM_THREADS-1]};
    assign threadQ104H = threadQ100H;  // Full turn

    always_ff @(posedge QClk) begin
        pcQ101H      <= pcQ100H;
        rs1DataQ102H <= rs1DataQ101H;
        rs2DataQ102H <= rs2DataQ101H;
    end

    threadScheduler #(.bootStride(bootStride)) threadScheduler_i (
        .QClk, .reset, .threadEnable, .threadRestart, .nextPcQ102H, .insertNopQ102H,
        .threadQ100H, .pcQ100H, .insertNopQ101H
    );

    decodeStage decodeStage_i (
        .QClk, .reset, .instFetchQ101H, .insertNopQ101H, .pcQ101H,
        .instructionQ102H, .pcQ102H, .rs1PtrQ101H, .rs2PtrQ101H,
        .jalQ102H, .jalrQ102H, .branchQ102H, .iTypeImmQ102H, .luiQ102H, .auiPcQ102H,
        .memRdQ102H, .memWrQ102H, .storeQ102H, .regWrQ102H, .memToRegQ102H,
        .pcToRegQ102H, .insertNopQ102H
    );

    registerFile registerFile_i (
        .QClk, .threadQ101H, .rs1PtrQ101H, .rs2PtrQ101H,
        .threadQ104H, .regWrQ104H, .rdPtrQ104H, .rdDataQ104H,
        .rs1DataQ101H, .rs2DataQ101H
    );

    executeStage executeStage_i (
        .QClk, .reset, .instructionQ102H, .pcQ102H, .rs1DataQ102H, .rs2DataQ102H,
        .jalQ102H, .jalrQ102H, .branchQ102H, .iTypeImmQ102H, .luiQ102H, .auiPcQ102H,
        .memRdQ102H, .memWrQ102H, .storeQ102H, .regWrQ102H, .memToRegQ102H,
        .pcToRegQ102H, .nextPcQ102H, .aluOutQ103H, .storeDataQ103H, .funct3Q103H,
        .rdPtrQ103H, .memRdQ103H, .memWrQ103H, .regWrQ103H, .memToRegQ103H,
        .pcToRegQ103H, .pcPlus4Q103H
    );

    memWriteback memWriteback_i (
        .QClk, .aluOutQ103H, .storeDataQ103H, .funct3Q103H, .rdPtrQ103H,
        .memRdQ103H, .memWrQ103H, .regWrQ103H, .memToRegQ103H, .pcToRegQ103H,
        .pcPlus4Q103H, .memRdDataQ104H, .memAdrsQ103H, .memWrDataQ103H,
        .memByteEnQ103H, .regWrQ104H, .rdPtrQ104H, .rdDataQ104H
    );

endmodule

`default_nettype wire

//--- src/memWriteback.sv
// Q103H memory access and Q104H write-back
// Byte enables and data memory outputs, Q104H registers,
// load extension and the write-back data mux
`timescale 1ns/1ps
`default_nettype none

module memWriteback import corePkg::*; (
    input  logic       QClk,
    input  xlenT       aluOutQ103H,
    input  xlenT       storeDataQ103H,
    input  logic [2:0] funct3Q103H,
    input  regPtrT     rdPtrQ103H,
    input  logic       memRdQ103H,
    input  logic       memWrQ103H,
    input  logic       regWrQ103H,
    input  logic       memToRegQ103H,
    input  logic       pcToRegQ103H,
    input  xlenT       pcPlus4Q103H,
    input  xlenT       memRdDataQ104H,
    output xlenT       memAdrsQ103H,
    output xlenT       memWrDataQ103H,
    output byteEnT     memByteEnQ103H,
    output logic       regWrQ104H,
    output regPtrT     rdPtrQ104H,
    output xlenT       rdDataQ104H
);

    xlenT       aluOutQ104H, pcPlus4Q104H, loadDataQ104H;
    logic [2:0] funct3Q104H;
    logic       memToRegQ104H, pcToRegQ104H;

    always_comb begin
        case (funct3Q103H[1:0])
            2'b00:   memByteEnQ103H = 4'b0001;  // Byte
            2'b01:   memByteEnQ103H = 4'b0011;  // Half
            2'b10:   memByteEnQ103H = 4'b1111;  // Word
            default: memByteEnQ103H = 4'b0000;
        endcase
    end

    assign memAdrsQ103H   = aluOutQ103H;
    assign memWrDataQ103H = storeDataQ103H;

    always_ff @(posedge QClk) begin
        {regWrQ104H, memToRegQ104H, pcToRegQ104H} <= {regWrQ103H, memToRegQ103H, pcToRegQ103H};
        rdPtrQ104H   <= rdPtrQ103H;
        funct3Q104H  <= funct3Q103H;
        aluOutQ104H  <= aluOutQ103H;
        pcPlus4Q104H <= pcPlus4Q103H;
    end

    // Loaded bytes sit in the low lanes
    always_comb begin
        case (funct3Q104H)
            3'b000:  loadDataQ104H = {{24{memRdDataQ104H[7]}}, memRdDataQ104H[7:0]};
            3'b001:  loadDataQ104H = {{16{memRdDataQ104H[15]}}, memRdDataQ104H[15:0]};
            3'b100:  loadDataQ104H = {24'b0, memRdDataQ104H[7:0]};   // LBU
            3'b101:  loadDataQ104H = {16'b0, memRdDataQ104H[15:0]};  // LHU
            default: loadDataQ104H = memRdDataQ104H;
        endcase
    end

    assign rdDataQ104H = memToRegQ104H ? loadDataQ104H :
                         pcToRegQ104H  ? pcPlus4Q104H  : aluOutQ104H;

    // Decode never raises both strobes for one slot
    assert property (@(posedge QClk) !(memRdQ103H && memWrQ103H));
    // Size code three is not an RV32I access
    assert property (@(posedge QClk) (memRdQ103H || memWrQ103H) |-> funct3Q103H[1:0] != 2'b11);

endmodule

`default_nettype wire

//--- src/executeStage.sv
// Q102H execute stage
// Immediate generation, ALU control and ALU, branch comparator,
// next-PC select and the Q102H to Q103H pipeline registers
`timescale 1ns/1ps
`default_nettype none

module executeStage import corePkg::*; (
    input  logic       QClk,
    input  logic       reset,
    input  xlenT       instructionQ102H,
    input  xlenT       pcQ102H,
    input  xlenT       rs1DataQ102H,
    input  xlenT       rs2DataQ102H,
    input  logic       jalQ102H,
    input  logic       jalrQ102H,
    input  logic       branchQ102H,
    input  logic       iTypeImmQ102H,
    input  logic       luiQ102H,
    input  logic       auiPcQ102H,
    input  logic       memRdQ102H,
    input  logic       memWrQ102H,
    input  logic       storeQ102H,
    input  logic       regWrQ102H,
    input  logic       memToRegQ102H,
    input  logic       pcToRegQ102H,
    output xlenT       nextPcQ102H,
    output xlenT       aluOutQ103H,
    output xlenT       storeDataQ103H,
    output logic [2:0] funct3Q103H,
    output regPtrT     rdPtrQ103H,
    output logic       memRdQ103H,
    output logic       memWrQ103H,
    output logic       regWrQ103H,
    output logic       memToRegQ103H,
    output logic       pcToRegQ103H,
    output xlenT       pcPlus4Q103H
);

    xlenT       iImmQ102H, sImmQ102H, bImmQ102H, uImmQ102H, jImmQ102H;
    xlenT       aluIn1Q102H, aluIn2Q102H, aluOutQ102H, pcPlus4Q102H;
    logic [2:0] funct3Q102H;
    logic [6:0] opcodeQ102H;
    aluOpT      aluOpQ102H;
    logic       branchTakenQ102H;

    assign opcodeQ102H = instructionQ102H[6:0];
    assign funct3Q102H = instructionQ102H[14:12];

    ///////////////////////////////////////////////////////////////////
    // Immediates
    ///////////////////////////////////////////////////////////////////
    assign iImmQ102H = {{20{instructionQ102H[31]}}, instructionQ102H[31:20]};
    assign sImmQ102H = {{20{instructionQ102H[31]}}, instructionQ102H[31:25],
                        instructionQ102H[11:7]};
    assign bImmQ102H = {{20{instructionQ102H[31]}}, instructionQ102H[7],
                        instructionQ102H[30:25], instructionQ102H[11:8], 1'b0};
    assign uImmQ102H = {instructionQ102H[31:12], 12'b0};
    assign jImmQ102H = {{12{instructionQ102H[31]}}, instructionQ102H[19:12],
                        instructionQ102H[20], instructionQ102H[30:21], 1'b0};

    // funct7[5] only means SUB/SRA for OP and the OP-IMM shifts
    always_comb begin
        aluOpQ102H = ALU_ADD;  // LUI, AUIPC, address math
        if (opcodeQ102H == OP_OP || opcodeQ102H == OP_OPIMM) begin
            aluOpQ102H = {1'b0, funct3Q102H};
            aluOpQ102H[3] = instructionQ102H[30] &&
                (opcodeQ102H == OP_OP || funct3Q102H[1:0] == 2'b01);
        end
    end

    always_comb begin
        aluIn1Q102H = rs1DataQ102H;
        aluIn2Q102H = rs2DataQ102H;        // OP, BRANCH
        if (luiQ102H) begin
            aluIn1Q102H = '0;
            aluIn2Q102H = uImmQ102H;
        end else if (auiPcQ102H) begin
            aluIn1Q102H = pcQ102H;
            aluIn2Q102H = uImmQ102H;
        end else if (iTypeImmQ102H) begin
            aluIn2Q102H = iImmQ102H;       // OP-IMM, LOAD, JALR
        end else if (storeQ102H) begin
            aluIn2Q102H = sImmQ102H;
        end
    end

    ///////////////////////////////////////////////////////////////////
    // ALU and branch comparator
    ///////////////////////////////////////////////////////////////////
    always_comb begin
        case (aluOpQ102H)
            ALU_SUB:  aluOutQ102H = aluIn1Q102H - aluIn2Q102H;
            ALU_SLT:  aluOutQ102H = xlenT'($signed(aluIn1Q102H) < $signed(aluIn2Q102H));
            ALU_SLTU: aluOutQ102H = xlenT'(aluIn1Q102H < aluIn2Q102H);
            ALU_SLL:  aluOutQ102H = aluIn1Q102H << aluIn2Q102H[4:0];
            ALU_SRL:  aluOutQ102H = aluIn1Q102H >> aluIn2Q102H[4:0];
            ALU_SRA:  aluOutQ102H = $signed(aluIn1Q102H) >>> aluIn2Q102H[4:0];
            ALU_XOR:  aluOutQ102H = aluIn1Q102H ^ aluIn2Q102H;
            ALU_OR:   aluOutQ102H = aluIn1Q102H | aluIn2Q102H;
            ALU_AND:  aluOutQ102H = aluIn1Q102H & aluIn2Q102H;
            default:  aluOutQ102H = aluIn1Q102H + aluIn2Q102H;  // ADD
        endcase
    end

    always_comb begin
        case (funct3Q102H)
            3'b000:  branchTakenQ102H = rs1DataQ102H == rs2DataQ102H;  // BEQ
            3'b001:  branchTakenQ102H = rs1DataQ102H != rs2DataQ102H;  // BNE
            3'b100:  branchTakenQ102H = $signed(rs1DataQ102H) < $signed(rs2DataQ102H);
            3'b101:  branchTakenQ102H = $signed(rs1DataQ102H) >= $signed(rs2DataQ102H);
            3'b110:  branchTakenQ102H = rs1DataQ102H < rs2DataQ102H;   // BLTU
            3'b111:  branchTakenQ102H = rs1DataQ102H >= rs2DataQ102H;  // BGEU
            default: branchTakenQ102H = 1'b0;
        endcase
    end

    assign pcPlus4Q102H = pcQ102H + 32'd4;

    always_comb begin
        if (jalrQ102H)                          nextPcQ102H = {aluOutQ102H[31:1], 1'b0};
        else if (jalQ102H)                      nextPcQ102H = pcQ102H + jImmQ102H;
        else if (branchQ102H && branchTakenQ102H) nextPcQ102H = pcQ102H + bImmQ102H;
        else                                    nextPcQ102H = pcPlus4Q102H;
    end

    ///////////////////////////////////////////////////////////////////
    // Q103H registers
    ///////////////////////////////////////////////////////////////////
    always_ff @(posedge QClk) begin
        if (reset) begin
            {memRdQ103H, memWrQ103H, regWrQ103H, memToRegQ103H, pcToRegQ103H} <= '0;
        end else begin
            {memRdQ103H, memWrQ103H, regWrQ103H, memToRegQ103H, pcToRegQ103H} <=
                {memRdQ102H, memWrQ102H, regWrQ102H, memToRegQ102H, pcToRegQ102H};
        end
    end

    always_ff @(posedge QClk) begin
        aluOutQ103H    <= aluOutQ102H;
        storeDataQ103H <= rs2DataQ102H;
        funct3Q103H    <= funct3Q102H;
        rdPtrQ103H     <= instructionQ102H[11:7];
        pcPlus4Q103H   <= pcPlus4Q102H;  // Link value
    end

endmodule

`default_nettype wire

//--- src/registerFile.sv
// Thread-banked integer register file
// One 32 x 32 bank per thread, two read ports at Q101H
// and one write port at Q104H, x0 reads as zero
`timescale 1ns/1ps
`default_nettype none

module registerFile import corePkg::*; (
    input  logic   QClk,
    input  threadT threadQ101H,
    input  regPtrT rs1PtrQ101H,
    input  regPtrT rs2PtrQ101H,
    input  threadT threadQ104H,
    input  logic   regWrQ104H,
    input  regPtrT rdPtrQ104H,
    input  xlenT   rdDataQ104H,
    output xlenT   rs1DataQ101H,
    output xlenT   rs2DataQ101H
);

    localparam int NUM_REGS = 2 ** $bits(regPtrT);

    xlenT bankMem [NUM_THREADS][NUM_REGS];  // No reset on storage
    xlenT rs1RawQ101H;
    xlenT rs2RawQ101H;

    ///////////////////////////////////////////////////////////////////
    // Write port
    ///////////////////////////////////////////////////////////////////
    // Lands before the same thread's next Q101H read
    always_ff @(posedge QClk) begin
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (regWrQ104H && threadQ104H[t]) begin
                bankMem[t][rdPtrQ104H] <= rdDataQ104H;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////
    // Read ports
    ///////////////////////////////////////////////////////////////////
    always_comb begin
        rs1RawQ101H = '0;
        rs2RawQ101H = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (threadQ101H[t]) begin  // Bank of the decoding thread
                rs1RawQ101H = bankMem[t][rs1PtrQ101H];
                rs2RawQ101H = bankMem[t][rs2PtrQ101H];
            end
        end
    end

    // x0 masked on read, so writes to it are harmless
    assign rs1DataQ101H = (rs1PtrQ101H == '0) ? '0 : rs1RawQ101H;
    assign rs2DataQ101H = (rs2PtrQ101H == '0) ? '0 : rs2RawQ101H;

endmodule

`default_nettype wire

//--- src/decodeStage.sv
// Q101H decode stage
// NOP substitution, register read pointers, opcode decode
// and the Q101H to Q102H pipeline registers
`timescale 1ns/1ps
`default_nettype none

module decodeStage import corePkg::*; (
    input  logic   QClk,
    input  logic   reset,
    input  xlenT   instFetchQ101H,
    input  logic   insertNopQ101H,
    input  xlenT   pcQ101H,
    output xlenT   instructionQ102H,
    output xlenT   pcQ102H,
    output regPtrT rs1PtrQ101H,
    output regPtrT rs2PtrQ101H,
    output logic   jalQ102H,
    output logic   jalrQ102H,
    output logic   branchQ102H,
    output logic   iTypeImmQ102H,
    output logic   luiQ102H,
    output logic   auiPcQ102H,
    output logic   memRdQ102H,
    output logic   memWrQ102H,
    output logic   storeQ102H,
    output logic   regWrQ102H,
    output logic   memToRegQ102H,
    output logic   pcToRegQ102H,
    output logic   insertNopQ102H
);

    xlenT       instructionQ101H;
    logic [6:0] opcodeQ101H;

    assign instructionQ101H = insertNopQ101H ? NOP : instFetchQ101H;
    assign opcodeQ101H      = instructionQ101H[6:0];
    assign rs1PtrQ101H      = instructionQ101H[19:15];  // R/I/S/B
    assign rs2PtrQ101H      = instructionQ101H[24:20];  // R/S/B

    ///////////////////////////////////////////////////////////////////
    // Opcode decode straight into the Q102H flops
    ///////////////////////////////////////////////////////////////////
    always_ff @(posedge QClk) begin
        if (reset) begin
            {jalQ102H, jalrQ102H, branchQ102H, iTypeImmQ102H, luiQ102H, auiPcQ102H} <= '0;
            {memRdQ102H, memWrQ102H, storeQ102H, regWrQ102H} <= '0;
            {memToRegQ102H, pcToRegQ102H} <= '0;
            insertNopQ102H <= 1'b1;  // Pipe starts empty
        end else begin
            jalQ102H       <= opcodeQ101H == OP_JAL;
            jalrQ102H      <= opcodeQ101H == OP_JALR;
            branchQ102H    <= opcodeQ101H == OP_BRANCH;
            iTypeImmQ102H  <= opcodeQ101H inside {OP_OPIMM, OP_LOAD, OP_JALR};
            luiQ102H       <= opcodeQ101H == OP_LUI;
            auiPcQ102H     <= opcodeQ101H == OP_AUIPC;
            memRdQ102H     <= opcodeQ101H == OP_LOAD;
            memWrQ102H     <= opcodeQ101H == OP_STORE;
            storeQ102H     <= opcodeQ101H == OP_STORE;   // S-type immediate
            regWrQ102H     <= !(opcodeQ101H inside {OP_STORE, OP_BRANCH});
            memToRegQ102H  <= opcodeQ101H == OP_LOAD;
            pcToRegQ102H   <= opcodeQ101H inside {OP_JAL, OP_JALR};  // Link
            insertNopQ102H <= insertNopQ101H;
        end
    end

    always_ff @(posedge QClk) begin
        instructionQ102H <= instructionQ101H;
        pcQ102H          <= pcQ101H;
    end

endmodule

`default_nettype wire

//--- src/threadScheduler.sv
// Barrel thread scheduler
// One-hot thread rotation, per-thread program counters with
// enable and restart, fetch PC mux and NOP marking of idle slots
`timescale 1ns/1ps
`default_nettype none

module threadScheduler import corePkg::*; #(
    parameter xlenT bootStride = 32'h400
) (
    input  logic   QClk,
    input  logic   reset,
    input  threadT threadEnable,    // Level per thread
    input  threadT threadRestart,   // Pulse per thread
    input  xlenT   nextPcQ102H,
    input  logic   insertNopQ102H,
    output threadT threadQ100H,
    output xlenT   pcQ100H,
    output logic   insertNopQ101H
);

    threadT threadQ102H;
    xlenT   threadPcQnnnH [NUM_THREADS];
    logic   insertNopQ100H;

    ///////////////////////////////////////////////////////////////////
    // Thread rotation
    ///////////////////////////////////////////////////////////////////
    always_ff @(posedge QClk) begin
        if (reset) threadQ100H <= threadT'(1);  // Thread 0 first
        else       threadQ100H <= {threadQ100H[NUM_THREADS-2:0], threadQ100H[NUM_THREADS-1]};
    end

    // Two slots behind the fetch slot
    assign threadQ102H = {threadQ100H[1:0], threadQ100H[NUM_THREADS-1:2]};

    ///////////////////////////////////////////////////////////////////
    // Program counters
    ///////////////////////////////////////////////////////////////////
    // A slot fetched while disabled carries the NOP flag, so the flag
    // alone decides whether the owner's PC advances
    always_ff @(posedge QClk) begin
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (reset || threadRestart[t]) begin
                threadPcQnnnH[t] <= xlenT'(t) * bootStride;  // Boot address
            end else if (threadQ102H[t] && !insertNopQ102H) begin
                threadPcQnnnH[t] <= nextPcQ102H;
            end
        end
    end

    always_comb begin
        pcQ100H = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (threadQ100H[t]) pcQ100H = threadPcQnnnH[t];  // Fetch mux
        end
    end

    assign insertNopQ100H = |(threadQ100H & ~threadEnable);  // Idle slot

    always_ff @(posedge QClk) begin
        if (reset) insertNopQ101H <= 1'b1;
        else       insertNopQ101H <= insertNopQ100H;
    end

    // Pointer stays one-hot
    assert property (@(posedge QClk) !reset |-> $onehot(threadQ100H));

endmodule

`default_nettype wire

//--- src/corePkg.sv
// Shared definitions for the four-thread barrel core
// Word, register pointer, thread, ALU op and byte-enable types
// RV32I opcode constants, ALU operation codes and the NOP word
`default_nettype none

package corePkg;

    localparam int XLEN        = 32;
    localparam int NUM_THREADS = 4;

    typedef logic [XLEN-1:0]        xlenT;    // Data and address word
    typedef logic [4:0]             regPtrT;  // Register index
    typedef logic [NUM_THREADS-1:0] threadT;  // One-hot thread pointer
    typedef logic [3:0]             aluOpT;   // {funct7[5], funct3}
    typedef logic [3:0]             byteEnT;  // Data memory lane mask

    ///////////////////////////////////////////////////////////////////
    // RV32I major opcodes
    ///////////////////////////////////////////////////////////////////
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;

    ///////////////////////////////////////////////////////////////////
    // ALU operations, bit 3 set only for SUB and SRA
    ///////////////////////////////////////////////////////////////////
    localparam aluOpT ALU_ADD  = 4'b0000;
    localparam aluOpT ALU_SUB  = 4'b1000;
    localparam aluOpT ALU_SLL  = 4'b0001;
    localparam aluOpT ALU_SLT  = 4'b0010;
    localparam aluOpT ALU_SLTU = 4'b0011;
    localparam aluOpT ALU_XOR  = 4'b0100;
    localparam aluOpT ALU_SRL  = 4'b0101;
    localparam aluOpT ALU_SRA  = 4'b1101;
    localparam aluOpT ALU_OR   = 4'b0110;
    localparam aluOpT ALU_AND  = 4'b0111;

    localparam xlenT NOP = 32'h0000_0013;  // addi x0,x0,0

endpackage

`default_nettype wire
